// ==== src/sb_params.svh ====
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// architectural registers, r0 always reads as ready
`define SB_NUM_REGS 32

// issue lanes, also the number of writeback lanes
`define SB_NUM_LANES 2

// source operand lookups per cycle
`define SB_NUM_RPORTS 4

// shared issue counter width
// value 0 is never handed out
`define SB_TID_W 3

`endif

// ==== src/sb_pkg.sv ====
`include "sb_params.svh"

package sb_pkg;

  // architectural register index
  typedef logic [$clog2(`SB_NUM_REGS)-1:0] reg_addr_t;

  // shared issue counter value
  typedef logic [`SB_TID_W-1:0] tid_t;

  // producer tag, tid with the lane number as bit 0
  typedef logic [`SB_TID_W:0] sb_tag_t;

  // tag 0 means the value already sits in the register file
  localparam sb_tag_t tag_ready = '0;

  // counter runs 1..7 and skips 0
  localparam tid_t tid_first = tid_t'(1);
  localparam tid_t tid_last  = '1;

  // lane 0 gets {tid,0}, lane 1 gets {tid,1}
  function automatic sb_tag_t make_tag(input tid_t tid, input logic lane);
    return {tid, lane};
  endfunction

endpackage

// ==== src/issue_board.sv ====
`timescale 1ns/1ps
`include "sb_params.svh"

module issue_board
  import sb_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic      [`SB_NUM_LANES-1:0]       is_i,
  input  reg_addr_t [`SB_NUM_LANES-1:0]       is_w_addr_i,
  input  reg_addr_t [`SB_NUM_RPORTS-1:0]      is_r_addr_i,
  output sb_tag_t   [`SB_NUM_LANES-1:0]       is_w_id_o,
  output sb_tag_t   [`SB_NUM_RPORTS-1:0]      is_r_tag_o
);

  // shared issue counter
  tid_t tid_q;
  tid_t tid_d;

  // per-lane write enable into the table
  logic [`SB_NUM_LANES-1:0] we;

  // tags handed to the current issue group
  sb_tag_t [`SB_NUM_LANES-1:0] w_tag;

  // newest producer tag per register
  // entry 0 stays at tag_ready forever
  sb_tag_t tag_q [`SB_NUM_REGS];

  // advance once per issue group, whichever lanes take part
  always_comb begin
    tid_d = tid_q;
    if (|is_i) begin
      if (tid_q == tid_last) begin
        tid_d = tid_first;
      end else begin
        tid_d = tid_q + tid_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_q <= tid_first;
    end else begin
      tid_q <= tid_d;
    end
  end

  // both lanes of a group share the current tid
  always_comb begin
    for (int l = 0; l < `SB_NUM_LANES; l++) begin
      w_tag[l] = make_tag(tid_q, 1'(l));
    end
  end

  // reported in the issue cycle so the core can carry it down the pipe
  assign is_w_id_o = w_tag;

  // r0 has no producer, its writes are dropped
  always_comb begin
    for (int l = 0; l < `SB_NUM_LANES; l++) begin
      we[l] = is_i[l] && (is_w_addr_i[l] != '0);
    end
  end

  // two write ports, destinations are distinct by contract
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `SB_NUM_REGS; r++) begin
        tag_q[r] <= tag_ready;
      end
    end else begin
      for (int l = 0; l < `SB_NUM_LANES; l++) begin
        if (we[l]) begin
          tag_q[is_w_addr_i[l]] <= w_tag[l];
        end
      end
    end
  end

  // reads see the table before this edge's updates
  always_comb begin
    for (int p = 0; p < `SB_NUM_RPORTS; p++) begin
      is_r_tag_o[p] = tag_q[is_r_addr_i[p]];
    end
  end

  // issue logic must never send two producers for one register
  a_dest_distinct: assert property (
    @(posedge clk) disable iff (!rst_n)
    (we[0] && we[1]) |-> (is_w_addr_i[0] != is_w_addr_i[1])
  ) else $error("issue_board: both lanes write r%0d", is_w_addr_i[0]);

  // tid 0 would alias the ready tag
  a_tid_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    tid_q != '0
  ) else $error("issue_board: counter reached 0");

endmodule

// ==== src/wb_board.sv ====
`timescale 1ns/1ps
`include "sb_params.svh"

module wb_board
  import sb_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic      [`SB_NUM_LANES-1:0]       wb_valid_i,
  input  reg_addr_t [`SB_NUM_LANES-1:0]       wb_w_addr_i,
  input  sb_tag_t   [`SB_NUM_LANES-1:0]       wb_w_id_i,
  input  reg_addr_t [`SB_NUM_RPORTS-1:0]      is_r_addr_i,
  output sb_tag_t   [`SB_NUM_RPORTS-1:0]      wb_r_tag_o
);

  // per-lane write enable, r0 never tracked
  logic [`SB_NUM_LANES-1:0] we;

  // last tag that reached the register file per register
  sb_tag_t tag_q [`SB_NUM_REGS];

  always_comb begin
    for (int l = 0; l < `SB_NUM_LANES; l++) begin
      we[l] = wb_valid_i[l] && (wb_w_addr_i[l] != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `SB_NUM_REGS; r++) begin
        tag_q[r] <= tag_ready;
      end
    end else begin
      for (int l = 0; l < `SB_NUM_LANES; l++) begin
        if (we[l]) begin
          tag_q[wb_w_addr_i[l]] <= wb_w_id_i[l];
        end
      end
    end
  end

  // old contents only, a same-cycle writeback shows up next cycle
  always_comb begin
    for (int p = 0; p < `SB_NUM_RPORTS; p++) begin
      wb_r_tag_o[p] = tag_q[is_r_addr_i[p]];
    end
  end

  // every writeback comes from a tag the issue board handed out
  a_wb_tag_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_valid_i[0] |-> (wb_w_id_i[0] != tag_ready)
  ) else $error("wb_board: lane 0 writes back tag 0");

  a_wb_tag_nonzero_l1: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_valid_i[1] |-> (wb_w_id_i[1] != tag_ready)
  ) else $error("wb_board: lane 1 writes back tag 0");

  // at most one producer per register is in flight
  a_wb_dest_distinct: assert property (
    @(posedge clk) disable iff (!rst_n)
    (we[0] && we[1]) |-> (wb_w_addr_i[0] != wb_w_addr_i[1])
  ) else $error("wb_board: both lanes write back r%0d", wb_w_addr_i[0]);

endmodule

// ==== src/operand_resolve.sv ====
`timescale 1ns/1ps
`include "sb_params.svh"

module operand_resolve
  import sb_pkg::*;
(
  input  sb_tag_t [`SB_NUM_RPORTS-1:0]  is_r_tag_i,
  input  sb_tag_t [`SB_NUM_RPORTS-1:0]  wb_r_tag_i,
  output sb_tag_t [`SB_NUM_RPORTS-1:0]  is_r_id_o,
  output logic    [`SB_NUM_RPORTS-1:0]  is_r_valid_o
);

  // no producer ever recorded, or r0
  logic [`SB_NUM_RPORTS-1:0] in_rf;

  // newest producer has already written back
  logic [`SB_NUM_RPORTS-1:0] wb_done;

  always_comb begin
    for (int p = 0; p < `SB_NUM_RPORTS; p++) begin
      in_rf[p]   = (is_r_tag_i[p] == tag_ready);
      wb_done[p] = (is_r_tag_i[p] == wb_r_tag_i[p]);
    end
  end

  // ready operands wait on nothing and report tag 0
  // otherwise the consumer waits on the newest producer
  always_comb begin
    for (int p = 0; p < `SB_NUM_RPORTS; p++) begin
      if (in_rf[p] || wb_done[p]) begin
        is_r_valid_o[p] = 1'b1;
        is_r_id_o[p]    = tag_ready;
      end else begin
        is_r_valid_o[p] = 1'b0;
        is_r_id_o[p]    = is_r_tag_i[p];
      end
    end
  end

endmodule

// ==== src/scoreboard.sv ====
`timescale 1ns/1ps
`include "sb_params.svh"

module scoreboard
  import sb_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_n,

  // source operand lookup
  input  reg_addr_t [`SB_NUM_RPORTS-1:0]      is_r_addr_i,

  // issue group
  input  logic      [`SB_NUM_LANES-1:0]       is_i,
  input  reg_addr_t [`SB_NUM_LANES-1:0]       is_w_addr_i,

  // writeback, tag is the one reported at issue
  input  logic      [`SB_NUM_LANES-1:0]       wb_valid_i,
  input  reg_addr_t [`SB_NUM_LANES-1:0]       wb_w_addr_i,
  input  sb_tag_t   [`SB_NUM_LANES-1:0]       wb_w_id_i,

  // lookup results
  output sb_tag_t   [`SB_NUM_RPORTS-1:0]      is_r_id_o,
  output logic      [`SB_NUM_RPORTS-1:0]      is_r_valid_o,

  // tags given to this cycle's issue group
  output sb_tag_t   [`SB_NUM_LANES-1:0]       is_w_id_o
);

  // newest producer per read port
  sb_tag_t [`SB_NUM_RPORTS-1:0] is_r_tag;

  // last written-back tag per read port
  sb_tag_t [`SB_NUM_RPORTS-1:0] wb_r_tag;

  issue_board u_issue_board (
    .clk         (clk),
    .rst_n       (rst_n),
    .is_i        (is_i),
    .is_w_addr_i (is_w_addr_i),
    .is_r_addr_i (is_r_addr_i),
    .is_w_id_o   (is_w_id_o),
    .is_r_tag_o  (is_r_tag)
  );

  wb_board u_wb_board (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_valid_i  (wb_valid_i),
    .wb_w_addr_i (wb_w_addr_i),
    .wb_w_id_i   (wb_w_id_i),
    .is_r_addr_i (is_r_addr_i),
    .wb_r_tag_o  (wb_r_tag)
  );

  // both views meet only here
  operand_resolve u_operand_resolve (
    .is_r_tag_i   (is_r_tag),
    .wb_r_tag_i   (wb_r_tag),
    .is_r_id_o    (is_r_id_o),
    .is_r_valid_o (is_r_valid_o)
  );

endmodule

// ==== verif/tb_scoreboard.sv ====
`timescale 1ns/1ps
`include "sb_params.svh"

module tb_scoreboard
  import sb_pkg::*;
();

  localparam int RAND_CYCLES = 2000;
  // directed part and drain take well under 100 cycles
  localparam int MAX_CYCLES  = 3000;

  logic                              clk;
  logic                              rst_n;
  reg_addr_t [`SB_NUM_RPORTS-1:0]    is_r_addr;
  logic      [`SB_NUM_LANES-1:0]     is_i;
  reg_addr_t [`SB_NUM_LANES-1:0]     is_w_addr;
  logic      [`SB_NUM_LANES-1:0]     wb_valid;
  reg_addr_t [`SB_NUM_LANES-1:0]     wb_w_addr;
  sb_tag_t   [`SB_NUM_LANES-1:0]     wb_w_id;
  sb_tag_t   [`SB_NUM_RPORTS-1:0]    is_r_id;
  logic      [`SB_NUM_RPORTS-1:0]    is_r_valid;
  sb_tag_t   [`SB_NUM_LANES-1:0]     is_w_id;

  int          cyc_count;
  int          errors;
  logic [31:0] rng_state = 32'h9c9d;

  // reference state: counter, newest issue tag, last writeback tag
  tid_t    ref_tid;
  sb_tag_t ref_is_tab [`SB_NUM_REGS];
  sb_tag_t ref_wb_tab [`SB_NUM_REGS];

  // pending writebacks and open lanes per issue group
  reg_addr_t pend_addr[$];
  sb_tag_t   pend_tag[$];
  int        pend_due[$];
  int        grp_left [8];

  scoreboard dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .is_r_addr_i  (is_r_addr),
    .is_i         (is_i),
    .is_w_addr_i  (is_w_addr),
    .wb_valid_i   (wb_valid),
    .wb_w_addr_i  (wb_w_addr),
    .wb_w_id_i    (wb_w_id),
    .is_r_id_o    (is_r_id),
    .is_r_valid_o (is_r_valid),
    .is_w_id_o    (is_w_id)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_count <= cyc_count + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // {ready, wait tag} for one register, from the resolver rule
  function automatic logic [4:0] expect_read(input reg_addr_t addr);
    sb_tag_t it;
    it = ref_is_tab[addr];
    if (it == 4'd0 || it == ref_wb_tab[addr]) begin
      return {1'b1, 4'd0};
    end
    return {1'b0, it};
  endfunction

  task automatic abort_run();
    errors++;
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic reset_model();
    ref_tid = 3'd1;
    for (int r = 0; r < `SB_NUM_REGS; r++) begin
      ref_is_tab[r] = 4'd0;
      ref_wb_tab[r] = 4'd0;
    end
  endtask

  task automatic check_outputs();
    logic [4:0] exp;
    for (int p = 0; p < `SB_NUM_RPORTS; p++) begin
      exp = expect_read(is_r_addr[p]);
      check_val($sformatf("is_r_valid_o[%0d]", p), 8'(exp[4]), 8'(is_r_valid[p]));
      check_val($sformatf("is_r_id_o[%0d]", p), 8'(exp[3:0]), 8'(is_r_id[p]));
    end
    for (int l = 0; l < `SB_NUM_LANES; l++) begin
      check_val($sformatf("is_w_id_o[%0d]", l), 8'({ref_tid, 1'(l)}), 8'(is_w_id[l]));
    end
  endtask

  // what the coming edge does to the boards
  task automatic update_model();
    for (int l = 0; l < `SB_NUM_LANES; l++) begin
      if (is_i[l] && is_w_addr[l] != '0) ref_is_tab[is_w_addr[l]] = {ref_tid, 1'(l)};
      if (wb_valid[l] && wb_w_addr[l] != '0) ref_wb_tab[wb_w_addr[l]] = wb_w_id[l];
    end
    if (is_i != '0) ref_tid = (ref_tid == 3'd7) ? 3'd1 : ref_tid + 3'd1;
  endtask

  // compare 1 ns before each rising edge
  initial begin
    reset_model();
    forever begin
      @(posedge clk);
      #3;
      if (!rst_n) begin
        reset_model();
      end else begin
        check_outputs();
        update_model();
      end
    end
  end

  initial begin
    wait (cyc_count >= MAX_CYCLES);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    abort_run();
  end

  task automatic next_cycle();
    @(posedge clk);
    #0.5;
    is_i     = '0;
    wb_valid = '0;
  endtask

  task automatic drive_issue(input int lane, input reg_addr_t addr);
    is_i[lane]      = 1'b1;
    is_w_addr[lane] = addr;
  endtask

  task automatic drive_wb(input int lane, input reg_addr_t addr, input sb_tag_t tag);
    wb_valid[lane]  = 1'b1;
    wb_w_addr[lane] = addr;
    wb_w_id[lane]   = tag;
  endtask

  task automatic set_reads(input reg_addr_t a0, a1, a2, a3);
    is_r_addr = {a3, a2, a1, a0};
  endtask

  task automatic check_issue_tags(input sb_tag_t e0, input sb_tag_t e1);
    #2.5;
    check_val("is_w_id_o[0]", 8'(e0), 8'(is_w_id[0]));
    check_val("is_w_id_o[1]", 8'(e1), 8'(is_w_id[1]));
  endtask

  task automatic random_reads();
    rng_state = xorshift32(rng_state);
    for (int p = 0; p < `SB_NUM_RPORTS - 1; p++) begin
      is_r_addr[p] = {2'b00, rng_state[p*5 +: 3]};
    end
    // last port also covers the upper registers
    is_r_addr[3] = rng_state[20:16];
  endtask

  task automatic random_issue();
    int   in_flight;
    logic [2:0] a0;
    in_flight = 0;
    for (int t = 1; t < 8; t++) in_flight += (grp_left[t] != 0);
    rng_state = xorshift32(rng_state);
    if (in_flight < 7 && grp_left[ref_tid] == 0 && rng_state[0]) begin
      a0 = rng_state[10:8];
      is_w_addr[0] = {2'b00, a0};
      // offset 1..7 keeps the lanes apart
      is_w_addr[1] = {2'b00, a0 + 3'd1 + 3'(rng_state[13:11] % 7)};
      is_i = rng_state[2:1];
      for (int l = 0; l < `SB_NUM_LANES; l++) begin
        if (is_i[l] && is_w_addr[l] != '0) begin
          pend_addr.push_back(is_w_addr[l]);
          pend_tag.push_back({ref_tid, 1'(l)});
          pend_due.push_back(cyc_count + 1 + int'(rng_state[31:16] % 6));
          grp_left[ref_tid]++;
        end
      end
    end
  endtask

  task automatic random_writebacks();
    int i;
    int picked;
    i = 0;
    picked = 0;
    while (i < pend_tag.size() && picked < 2) begin
      if (pend_due[i] <= cyc_count && !(picked == 1 && pend_addr[i] == wb_w_addr[0])) begin
        drive_wb(picked, pend_addr[i], pend_tag[i]);
        grp_left[pend_tag[i][3:1]]--;
        picked++;
        pend_addr.delete(i);
        pend_tag.delete(i);
        pend_due.delete(i);
      end else begin
        i++;
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    is_i = '0;
    is_w_addr = '0;
    wb_valid = '0;
    wb_w_addr = '0;
    wb_w_id = '0;
    is_r_addr = '0;
    errors = 0;
    for (int t = 0; t < 8; t++) grp_left[t] = 0;
    repeat (2) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    // reset state, then first group gets tid 1
    next_cycle();
    set_reads(5'd0, 5'd1, 5'd2, 5'd3);
    next_cycle();
    drive_issue(0, 5'd1);
    drive_issue(1, 5'd2);
    check_issue_tags(4'd2, 4'd3);
    // writeback in the read cycle, plus an issue to r0
    next_cycle();
    drive_wb(0, 5'd1, 4'd2);
    drive_issue(0, 5'd0);
    drive_issue(1, 5'd3);
    // issue and writeback to r2 in one cycle
    next_cycle();
    drive_issue(0, 5'd2);
    drive_wb(0, 5'd2, 4'd3);
    next_cycle();
    set_reads(5'd4, 5'd2, 5'd3, 5'd0);
    drive_wb(0, 5'd3, 4'd5);
    drive_issue(0, 5'd4);
    next_cycle();
    next_cycle();
    drive_issue(1, 5'd4);
    // older tag 8 after newer tag 11
    next_cycle();
    drive_wb(0, 5'd4, 4'd8);
    drive_wb(1, 5'd2, 4'd6);
    next_cycle();
    drive_wb(0, 5'd4, 4'd11);
    next_cycle();
    // tid 6 and 7, then wrap back to 1
    next_cycle();
    set_reads(5'd5, 5'd6, 5'd7, 5'd1);
    drive_issue(0, 5'd5);
    next_cycle();
    drive_issue(1, 5'd6);
    next_cycle();
    next_cycle();
    drive_issue(0, 5'd7);
    drive_issue(1, 5'd1);
    check_issue_tags(4'd2, 4'd3);
    next_cycle();
    drive_wb(0, 5'd5, 4'd12);
    drive_wb(1, 5'd6, 4'd15);
    next_cycle();
    drive_wb(0, 5'd7, 4'd2);
    drive_wb(1, 5'd1, 4'd3);

    for (int c = 0; c < RAND_CYCLES; c++) begin
      next_cycle();
      random_reads();
      random_issue();
      random_writebacks();
    end
    while (pend_tag.size() > 0) begin
      next_cycle();
      random_reads();
      random_writebacks();
    end
    repeat (3) next_cycle();
    @(posedge clk);

    if (errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "run aborted");
    end
  end

endmodule

// ==== scoreboard.f ====
+incdir+src
src/sb_pkg.sv
src/issue_board.sv
src/wb_board.sv
src/operand_resolve.sv
src/scoreboard.sv
verif/tb_scoreboard.sv

// ==== Bender.yml ====
package:
  name: scoreboard

sources:
  - include_dirs:
      - src
    files:
      - src/sb_pkg.sv
      - src/issue_board.sv
      - src/wb_board.sv
      - src/operand_resolve.sv
      - src/scoreboard.sv

  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_scoreboard.sv
